// File: design/mdu_data_pkg.sv
`default_nettype none

// Widths and word types of the multiply/divide data path
package mdu_data_pkg;

    localparam int word_bits = 32;
    localparam int dword_bits = 2 * word_bits;

    // One operand or one of the HI/LO registers
    typedef logic [word_bits-1:0] word_t;

    // Full product or HI/LO pair with HI in the upper half
    typedef logic [dword_bits-1:0] dword_t;

endpackage

`default_nettype wire

// File: design/mdu_op_pkg.sv
`default_nettype none

// Operation codes and the request/response bundles seen by the pipeline
package mdu_op_pkg;

    typedef enum logic [2:0] {
        op_none = 3'd0,
        op_mul  = 3'd1,  // Low word of the product to the result port
        op_mult = 3'd2,
        op_madd = 3'd3,
        op_msub = 3'd4,
        op_div  = 3'd5,  // Remainder to HI, quotient to LO
        op_mthi = 3'd6,
        op_mtlo = 3'd7
    } mdu_op_e;

    typedef struct packed {
        mdu_op_e             op;
        logic                is_unsigned;
        mdu_data_pkg::word_t operand_a;
        mdu_data_pkg::word_t operand_b;
    } mdu_req_t;

    typedef struct packed {
        logic                done;
        mdu_data_pkg::word_t result;
    } mdu_resp_t;

endpackage

`default_nettype wire

// File: design/radix2_divider.sv
`timescale 1ns/1ps
`default_nettype none

// Restoring shift-subtract divider for unsigned magnitudes.
// One quotient bit is produced per clock, MSB first.
module radix2_divider #(
    parameter int width = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  logic             start,
    input  logic [width-1:0] dividend,
    input  logic [width-1:0] divisor,
    output logic [width-1:0] quotient,
    output logic [width-1:0] remainder,
    output logic             done
);

    localparam int cnt_bits = $clog2(width + 1);

    logic                busy;
    logic [cnt_bits-1:0] count;
    logic [width-1:0]    rem_q;
    logic [width-1:0]    quo_q;    // Dividend bits shift out as quotient bits shift in
    logic [width-1:0]    div_q;
    logic [width:0]      partial;
    logic [width:0]      diff;
    logic                fits;
    logic                last_step;

    // Partial remainder with the next dividend bit brought down
    assign partial = {rem_q, quo_q[width-1]};
    assign diff = partial - {1'b0, div_q};
    assign fits = (partial >= {1'b0, div_q});  // Always true for a zero divisor
    assign last_step = (count == cnt_bits'(width - 1));

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy <= 1'b0;
            done <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + cnt_bits'(1);
                if (last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;  // Quotient and remainder settle at this same edge
                end
            end
        end
    end

    // With a zero divisor every step subtracts nothing, so the quotient
    // fills with ones and the dividend ends up in the remainder
    always_ff @(posedge clk) begin
        if (start) begin
            rem_q <= '0;
            quo_q <= dividend;
            div_q <= divisor;
        end else if (busy) begin
            if (fits) begin
                rem_q <= diff[width-1:0];
            end else begin
                rem_q <= partial[width-1:0];
            end
            quo_q <= {quo_q[width-2:0], fits};
        end
    end

    assign quotient = quo_q;
    assign remainder = rem_q;

    // The sequencing unit must not fire a second division over a running one
    assert property (@(posedge clk) disable iff (reset) start |-> !busy)
        else $error("Divider start while a division is still running");

endmodule

`default_nettype wire

// File: design/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

// Sequencing and sign handling for the multiply/divide unit.
// The multiplier works on magnitudes and the sign is put back afterwards.
module muldiv_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  mdu_op_pkg::mdu_req_t    req,
    input  mdu_data_pkg::dword_t    hilo,
    output mdu_op_pkg::mdu_resp_t   resp,
    output logic                    hilo_we,
    output logic [1:0]              hilo_sel,
    output mdu_data_pkg::dword_t    hilo_wdata,
    output logic                    div_start,
    output mdu_data_pkg::word_t     div_dividend,
    output mdu_data_pkg::word_t     div_divisor,
    input  mdu_data_pkg::word_t     div_quotient,
    input  mdu_data_pkg::word_t     div_remainder,
    input  logic                    div_done
);

    localparam int msb = mdu_data_pkg::word_bits - 1;

    logic                 a_neg;
    logic                 b_neg;
    logic                 prod_neg;
    mdu_data_pkg::word_t  abs_a;
    mdu_data_pkg::word_t  abs_b;
    mdu_data_pkg::dword_t prod_q;
    mdu_data_pkg::dword_t prod_signed;
    mdu_data_pkg::word_t  quo_signed;
    mdu_data_pkg::word_t  rem_signed;
    logic [1:0]           stage;
    logic                 div_started;
    logic                 is_mul_family;
    logic                 is_move;

    assign a_neg = !req.is_unsigned && req.operand_a[msb];
    assign b_neg = !req.is_unsigned && req.operand_b[msb];
    assign abs_a = a_neg ? -req.operand_a : req.operand_a;
    assign abs_b = b_neg ? -req.operand_b : req.operand_b;
    assign prod_neg = a_neg ^ b_neg;

    assign is_mul_family = (req.op == mdu_op_pkg::op_mul) || (req.op == mdu_op_pkg::op_mult) ||
                           (req.op == mdu_op_pkg::op_madd) || (req.op == mdu_op_pkg::op_msub);
    assign is_move = (req.op == mdu_op_pkg::op_mthi) || (req.op == mdu_op_pkg::op_mtlo);

    // Operands are held by the pipeline, so the magnitude product can be taken every cycle
    always_ff @(posedge clk) begin
        prod_q <= mdu_data_pkg::dword_t'(abs_a) * mdu_data_pkg::dword_t'(abs_b);
    end

    assign prod_signed = prod_neg ? -prod_q : prod_q;

    // 10 marks the cycle the product is ready; 01 is a guard cycle
    // that stops a held op from starting again straight away
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            stage <= 2'b00;
        end else if (stage != 2'b00) begin
            stage <= stage >> 1;
        end else if (is_mul_family) begin
            stage <= 2'b10;
        end
    end

    // One divider start per DIV, rearmed once the pipeline goes idle
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            div_started <= 1'b0;
        end else if (div_start) begin
            div_started <= 1'b1;
        end else if (req.op == mdu_op_pkg::op_none) begin
            div_started <= 1'b0;
        end
    end

    assign div_start = (req.op == mdu_op_pkg::op_div) && !div_started;
    assign div_dividend = abs_a;
    assign div_divisor = abs_b;

    assign quo_signed = prod_neg ? -div_quotient : div_quotient;
    assign rem_signed = a_neg ? -div_remainder : div_remainder;  // Follows the dividend

    always_comb begin
        resp.done = !flush && (stage[1] || div_done || is_move);
        resp.result = '0;
        if (req.op == mdu_op_pkg::op_mul) begin
            resp.result = prod_signed[msb:0];
        end
    end

    // Select code 0 writes both halves, 1 only HI and 2 only LO
    always_comb begin
        hilo_we = 1'b0;
        hilo_sel = 2'd0;
        hilo_wdata = prod_signed;
        case (req.op)
            mdu_op_pkg::op_mult: begin
                hilo_we = stage[1];
            end
            mdu_op_pkg::op_madd: begin
                hilo_we = stage[1];
                hilo_wdata = hilo + prod_signed;
            end
            mdu_op_pkg::op_msub: begin
                hilo_we = stage[1];
                hilo_wdata = hilo - prod_signed;
            end
            mdu_op_pkg::op_div: begin
                hilo_we = div_done;
                hilo_wdata = {rem_signed, quo_signed};
            end
            mdu_op_pkg::op_mthi: begin
                hilo_we = 1'b1;
                hilo_sel = 2'd1;
                hilo_wdata = {req.operand_a, req.operand_a};
            end
            mdu_op_pkg::op_mtlo: begin
                hilo_we = 1'b1;
                hilo_sel = 2'd2;
                hilo_wdata = {req.operand_a, req.operand_a};
            end
            default: begin
                hilo_we = 1'b0;
            end
        endcase
        if (flush) begin
            hilo_we = 1'b0;  // An aborted op never reaches HI/LO
        end
    end

    // Sign fix-up and the MADD/MSUB sum read the live request in the done cycle
    assert property (@(posedge clk) disable iff (reset)
        (req.op != mdu_op_pkg::op_none && !resp.done && !flush) |=> $stable(req))
        else $error("Request changed while an operation was in progress");

endmodule

`default_nettype wire

// File: design/hilo_regs.sv
`timescale 1ns/1ps
`default_nettype none

// HI/LO register pair beside the arithmetic unit
module hilo_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 we,
    input  logic [1:0]           sel,
    input  mdu_data_pkg::dword_t wdata,
    output mdu_data_pkg::dword_t hilo
);

    localparam int msb = mdu_data_pkg::word_bits - 1;

    mdu_data_pkg::word_t hi_q;
    mdu_data_pkg::word_t lo_q;
    logic                write_hi;
    logic                write_lo;

    // sel 0 updates both halves, 1 only HI, 2 only LO
    assign write_hi = we && ((sel == 2'd0) || (sel == 2'd1));
    assign write_lo = we && ((sel == 2'd0) || (sel == 2'd2));

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
        end else if (write_hi) begin
            hi_q <= wdata[2*msb+1:msb+1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lo_q <= '0;
        end else if (write_lo) begin
            lo_q <= wdata[msb:0];
        end
    end

    assign hilo = {hi_q, lo_q};

    // Code 3 is not produced by the unit and would drop the write silently
    assert property (@(posedge clk) disable iff (reset) we |-> (sel != 2'd3))
        else $error("HI/LO write with unused select code");

endmodule

`default_nettype wire

// File: design/muldiv_top.sv
`timescale 1ns/1ps
`default_nettype none

// Multiply/divide unit with its divider and HI/LO registers
module muldiv_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  mdu_op_pkg::mdu_req_t  req,
    output mdu_op_pkg::mdu_resp_t resp,
    output mdu_data_pkg::dword_t  hilo
);

    logic                 hilo_we;
    logic [1:0]           hilo_sel;
    mdu_data_pkg::dword_t hilo_wdata;

    logic                 div_start;
    mdu_data_pkg::word_t  div_dividend;
    mdu_data_pkg::word_t  div_divisor;
    mdu_data_pkg::word_t  div_quotient;
    mdu_data_pkg::word_t  div_remainder;
    logic                 div_done;

    muldiv_unit u_unit (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .req           (req),
        .hilo          (hilo),
        .resp          (resp),
        .hilo_we       (hilo_we),
        .hilo_sel      (hilo_sel),
        .hilo_wdata    (hilo_wdata),
        .div_start     (div_start),
        .div_dividend  (div_dividend),
        .div_divisor   (div_divisor),
        .div_quotient  (div_quotient),
        .div_remainder (div_remainder),
        .div_done      (div_done)
    );

    radix2_divider #(
        .width (mdu_data_pkg::word_bits)
    ) u_divider (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .start     (div_start),
        .dividend  (div_dividend),
        .divisor   (div_divisor),
        .quotient  (div_quotient),
        .remainder (div_remainder),
        .done      (div_done)
    );

    // HI/LO goes back to the unit for MADD/MSUB and out to the pipeline
    hilo_regs u_hilo (
        .clk   (clk),
        .reset (reset),
        .we    (hilo_we),
        .sel   (hilo_sel),
        .wdata (hilo_wdata),
        .hilo  (hilo)
    );

endmodule

`default_nettype wire

// File: tests/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int period_ns = 10,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;  // Released on an edge like any other synchronous input
    end

endmodule

`default_nettype wire

// File: tests/muldiv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_tb;

    localparam int wb = mdu_data_pkg::word_bits;
    localparam int reset_cycles = 8;
    localparam int n_mult = 40;
    localparam int n_acc = 40;
    localparam int n_div = 40;
    localparam int n_mul = 20;
    localparam int n_move = 12;
    localparam int n_flush = 20;
    localparam int num_ops = n_mult + n_acc + n_div + n_mul + n_move + 2 * n_flush;
    localparam int cycle_limit = num_ops * (wb + 6) + reset_cycles;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    mdu_op_pkg::mdu_req_t  req;
    mdu_op_pkg::mdu_resp_t resp;
    mdu_data_pkg::dword_t  hilo;

    mdu_data_pkg::dword_t  model_hilo;  // HI/LO as the model expects it
    integer                seed = 32'h8d686ece;
    int                    cycles;
    int                    i;
    mdu_data_pkg::word_t   a;
    mdu_data_pkg::word_t   b;
    logic                  uns;

    clock_gen #(
        .period_ns    (10),
        .reset_cycles (reset_cycles)
    ) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    muldiv_top DUT (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .req   (req),
        .resp  (resp),
        .hilo  (hilo)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic compare(input string name, input mdu_data_pkg::dword_t actual,
                           input mdu_data_pkg::dword_t expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                        $time, name, actual, expected));
        end
    endtask

    function automatic int random_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Corner values show up often enough to hit the sign edge cases
    function automatic mdu_data_pkg::word_t pick_operand();
        int kind;
        kind = random_below(8);
        case (kind)
            0: return {1'b1, {(wb - 1){1'b0}}};  // Most negative value
            1: return '0;
            2: return '1;
            3: return mdu_data_pkg::word_t'(random_below(256));
            default: return $random(seed);
        endcase
    endfunction

    function automatic mdu_data_pkg::dword_t model_product(input mdu_data_pkg::word_t x,
                                                           input mdu_data_pkg::word_t y,
                                                           input logic uns_in);
        logic signed [2*wb-1:0] sx;
        logic signed [2*wb-1:0] sy;
        if (uns_in) begin
            return {{wb{1'b0}}, x} * {{wb{1'b0}}, y};
        end
        sx = {{wb{x[wb-1]}}, x};
        sy = {{wb{y[wb-1]}}, y};
        return sx * sy;
    endfunction

    // Result packed as remainder in HI and quotient in LO
    function automatic mdu_data_pkg::dword_t model_divide(input mdu_data_pkg::word_t dividend,
                                                          input mdu_data_pkg::word_t divisor,
                                                          input logic uns_in);
        logic signed [2*wb-1:0] sa;
        logic signed [2*wb-1:0] sb;
        mdu_data_pkg::word_t    q;
        mdu_data_pkg::word_t    r;
        if (divisor == '0) begin
            r = dividend;  // Magnitude kept, then the dividend's sign put back
            q = (!uns_in && dividend[wb-1]) ? mdu_data_pkg::word_t'(1) : '1;
        end else if (uns_in) begin
            q = dividend / divisor;
            r = dividend % divisor;
        end else begin
            sa = {{wb{dividend[wb-1]}}, dividend};
            sb = {{wb{divisor[wb-1]}}, divisor};
            q = mdu_data_pkg::word_t'(sa / sb);  // Truncates toward zero
            r = mdu_data_pkg::word_t'(sa % sb);  // Takes the dividend's sign
        end
        return {r, q};
    endfunction

    task automatic wait_for_done(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (resp.done !== 1'b1) begin
            if (waited > wb + 4) begin
                stop_with_failure($sformatf("no done pulse for %s after %0d cycles",
                                            what, waited));
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic run_op(input mdu_op_pkg::mdu_op_e op, input logic uns_in,
                          input mdu_data_pkg::word_t x, input mdu_data_pkg::word_t y);
        mdu_op_pkg::mdu_req_t r;
        mdu_data_pkg::dword_t prod;
        mdu_data_pkg::dword_t expect_hilo;
        mdu_data_pkg::word_t  expect_result;
        r.op = op;
        r.is_unsigned = uns_in;
        r.operand_a = x;
        r.operand_b = y;
        prod = model_product(x, y, uns_in);
        expect_hilo = model_hilo;
        expect_result = '0;
        case (op)
            mdu_op_pkg::op_mul: expect_result = prod[wb-1:0];
            mdu_op_pkg::op_mult: expect_hilo = prod;
            mdu_op_pkg::op_madd: expect_hilo = model_hilo + prod;
            mdu_op_pkg::op_msub: expect_hilo = model_hilo - prod;
            mdu_op_pkg::op_div: expect_hilo = model_divide(x, y, uns_in);
            mdu_op_pkg::op_mthi: expect_hilo = {x, model_hilo[wb-1:0]};
            mdu_op_pkg::op_mtlo: expect_hilo = {model_hilo[2*wb-1:wb], x};
            default: expect_hilo = model_hilo;
        endcase
        @(posedge clk);
        req <= r;
        wait_for_done(op.name());
        compare("resp.result", resp.result, expect_result);
        @(posedge clk);
        req.op <= mdu_op_pkg::op_none;
        @(negedge clk);
        compare("hilo", hilo, expect_hilo);
        model_hilo = expect_hilo;
    endtask

    // Flush lands after delay edges, before the op would have finished
    task automatic run_flushed(input mdu_op_pkg::mdu_op_e op, input logic uns_in,
                               input mdu_data_pkg::word_t x, input mdu_data_pkg::word_t y,
                               input int delay);
        mdu_op_pkg::mdu_req_t r;
        r.op = op;
        r.is_unsigned = uns_in;
        r.operand_a = x;
        r.operand_b = y;
        @(posedge clk);
        req <= r;
        repeat (delay) begin
            @(negedge clk);
            compare("resp.done", resp.done, '0);
            @(posedge clk);
        end
        flush <= 1'b1;
        @(negedge clk);
        compare("resp.done", resp.done, '0);
        @(posedge clk);
        flush <= 1'b0;
        req.op <= mdu_op_pkg::op_none;
        repeat (wb + 2) begin  // Long enough for a divide that escaped the flush to finish
            @(negedge clk);
            compare("resp.done", resp.done, '0);
        end
        compare("hilo", hilo, model_hilo);
    endtask

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        stop_with_failure($sformatf("timeout, run still going after %0d cycles", cycles));
    end

    initial begin
        req <= '0;
        flush <= 1'b0;
        model_hilo = '0;
        wait (reset === 1'b0);
        @(negedge clk);
        compare("resp.done", resp.done, '0);
        compare("hilo", hilo, model_hilo);
        for (i = 0; i < n_mult; i++) begin
            a = pick_operand();
            b = pick_operand();
            uns = (random_below(2) == 1);
            run_op(mdu_op_pkg::op_mult, uns, a, b);
        end
        for (i = 0; i < n_acc; i++) begin
            a = pick_operand();
            b = pick_operand();
            uns = (random_below(2) == 1);
            if (random_below(2) == 1) begin
                run_op(mdu_op_pkg::op_madd, uns, a, b);
            end else begin
                run_op(mdu_op_pkg::op_msub, uns, a, b);
            end
        end
        for (i = 0; i < n_div; i++) begin
            a = pick_operand();
            b = pick_operand();
            uns = (random_below(2) == 1);
            run_op(mdu_op_pkg::op_div, uns, a, b);
        end
        for (i = 0; i < n_mul; i++) begin
            a = pick_operand();
            b = pick_operand();
            uns = (random_below(2) == 1);
            run_op(mdu_op_pkg::op_mul, uns, a, b);
        end
        for (i = 0; i < n_move; i++) begin
            a = pick_operand();
            b = pick_operand();
            if (i % 2 == 0) begin
                run_op(mdu_op_pkg::op_mthi, 1'b0, a, b);
            end else begin
                run_op(mdu_op_pkg::op_mtlo, 1'b0, a, b);
            end
        end
        for (i = 0; i < n_flush; i++) begin
            a = pick_operand();
            b = pick_operand();
            uns = (random_below(2) == 1);
            if (i % 2 == 0) begin
                run_flushed(mdu_op_pkg::op_div, uns, a, b, random_below(wb + 2));
            end else begin
                run_flushed(mdu_op_pkg::op_mult, uns, a, b, random_below(2));
            end
            a = pick_operand();
            b = pick_operand();
            uns = (random_below(2) == 1);
            if (i % 2 == 0) begin
                run_op(mdu_op_pkg::op_div, uns, a, b);
            end else begin
                run_op(mdu_op_pkg::op_madd, uns, a, b);  // Builds on the HI/LO kept by flush
            end
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
design/mdu_data_pkg.sv
design/mdu_op_pkg.sv
design/radix2_divider.sv
design/muldiv_unit.sv
design/hilo_regs.sv
design/muldiv_top.sv
tests/clock_gen.sv
tests/muldiv_tb.sv

// File: Bender.yml
package:
  name: muldiv

dependencies: {}

sources:
  - design/mdu_data_pkg.sv
  - design/mdu_op_pkg.sv
  - design/radix2_divider.sv
  - design/muldiv_unit.sv
  - design/hilo_regs.sv
  - design/muldiv_top.sv
  - target: test
    files:
      - tests/clock_gen.sv
      - tests/muldiv_tb.sv
